/* src/ahbBusPkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared types for the AHB-Lite bus interface unit
// Single transfers only, no bursts, locking, protection or HRESP handling
// HADDR is fixed at 32 bits whatever the data width
////////////////////////////////////////////////////////////////////////////

package ahbBusPkg;

  // Bus FSM states
  typedef enum logic [2:0] {
    idle,
    memRead,
    memWrite,
    instrRead,
    atomicRead,
    atomicWrite
  } busStateT;

  // Atomic memory operations
  typedef enum logic [3:0] {
    amoSwap,
    amoAdd,
    amoXor,
    amoAnd,
    amoOr,
    amoMin,
    amoMax,
    amoMinu,
    amoMaxu
  } amoOpT;

  // HTRANS encodings in use
  localparam logic [1:0] htransIdle   = 2'b00;
  localparam logic [1:0] htransNonSeq = 2'b10;

  // Fetch request, held until instrStall is low at a clock edge
  typedef struct packed {
    logic        read;
    logic [31:0] adr;
  } instrReqT;

  // Data request, held until dataStall is low at a clock edge
  typedef struct packed {
    logic        read;
    logic        write;
    logic        atomic;
    amoOpT       amoOp;
    // log2 of the byte count
    logic [1:0]  size;
    logic        unsignedLoad;
    logic [31:0] adr;
  } dataReqT;

  // Address-phase outputs
  typedef struct packed {
    logic [31:0] haddr;
    logic [2:0]  hsize;
    logic        hwrite;
    logic [1:0]  htrans;
  } ahbAddrT;

  // Attributes of the transfer now in its data phase
  typedef struct packed {
    logic [2:0] lowAdr;
    logic [1:0] size;
    logic       unsignedLoad;
  } dataPhaseT;

endpackage

/* src/subwordRead.sv */
////////////////////////////////////////////////////////////////////////////
// Load extraction by size and low address bits
// Assumes naturally aligned accesses, Xlen of 32 or 64
////////////////////////////////////////////////////////////////////////////

module subwordRead #(
  parameter int Xlen = 64
) (
  input  logic [Xlen-1:0]      hrdata,
  input  ahbBusPkg::dataPhaseT dataPhase,
  output logic [Xlen-1:0]      readValue
);

  import ahbBusPkg::*;

  // Address bits that pick a byte lane
  localparam int ByteBits = $clog2(Xlen / 8);

  logic [Xlen-1:0] laneShift;
  logic            signBit;
  logic [63:0]     extended;
  dataPhaseT       phase;

  assign phase = dataPhase;

  // Move the addressed lane group down to bit 0
  assign laneShift = hrdata >> (8 * phase.lowAdr[ByteBits-1:0]);

  always_comb begin
    signBit  = 1'b0;
    extended = 64'(laneShift);
    case (phase.size)
      2'd0: begin
        signBit  = laneShift[7] & ~phase.unsignedLoad;
        extended = {{56{signBit}}, laneShift[7:0]};
      end
      2'd1: begin
        signBit  = laneShift[15] & ~phase.unsignedLoad;
        extended = {{48{signBit}}, laneShift[15:0]};
      end
      2'd2: begin
        signBit  = laneShift[31] & ~phase.unsignedLoad;
        extended = {{32{signBit}}, laneShift[31:0]};
      end
      // double is already full width
      default: extended = 64'(laneShift);
    endcase
  end

  assign readValue = extended[Xlen-1:0];

endmodule

/* src/amoAlu.sv */
////////////////////////////////////////////////////////////////////////////
// Atomic ALU at word or double width
// Word results are copied into every word lane of the bus
////////////////////////////////////////////////////////////////////////////

module amoAlu #(
  parameter int Xlen = 64
) (
  input  logic [Xlen-1:0]  srcOld,
  input  logic [Xlen-1:0]  srcNew,
  input  ahbBusPkg::amoOpT amoOp,
  input  logic [1:0]       size,
  output logic [Xlen-1:0]  result
);

  import ahbBusPkg::*;

  logic            isWord;
  logic            unsignedOp;
  logic [Xlen-1:0] opA;
  logic [Xlen-1:0] opB;
  logic            lessSigned;
  logic            lessUnsigned;
  logic [Xlen-1:0] full;

  // A 32-bit bus only has word atomics
  assign isWord     = (Xlen == 32) || (size == 2'd2);
  assign unsignedOp = amoOp inside {amoMinu, amoMaxu};

  // Word operands are widened so one compare serves both widths
  always_comb begin
    if (isWord && unsignedOp) begin
      opA = srcOld[31:0];
      opB = srcNew[31:0];
    end else if (isWord) begin
      opA = $signed(srcOld[31:0]);
      opB = $signed(srcNew[31:0]);
    end else begin
      opA = srcOld;
      opB = srcNew;
    end
  end

  assign lessSigned   = $signed(opA) < $signed(opB);
  assign lessUnsigned = opA < opB;

  always_comb begin
    case (amoOp)
      amoSwap: full = opB;
      amoAdd:  full = opA + opB;
      amoXor:  full = opA ^ opB;
      amoAnd:  full = opA & opB;
      amoOr:   full = opA | opB;
      amoMin:  full = lessSigned ? opA : opB;
      amoMax:  full = lessSigned ? opB : opA;
      amoMinu: full = lessUnsigned ? opA : opB;
      amoMaxu: full = lessUnsigned ? opB : opA;
      default: full = opB;
    endcase
  end

  // Slave keeps whichever lane its address selects
  assign result = isWord ? {(Xlen / 32){full[31:0]}} : full;

endmodule

/* src/ahbBusCtrl.sv */
////////////////////////////////////////////////////////////////////////////
// Bus FSM choosing between the data and fetch requesters
// Data wins from idle, a pending fetch follows any data transfer
// A request still held after completing counts as a new transfer
////////////////////////////////////////////////////////////////////////////

module ahbBusCtrl (
  input  logic                clk,
  input  logic                reset,
  input  ahbBusPkg::instrReqT instrReq,
  input  ahbBusPkg::dataReqT  dataReq,
  input  logic                hready,
  output ahbBusPkg::busStateT busState,
  output ahbBusPkg::busStateT nextState,
  output logic                captureOld,
  output logic                instrStall,
  output logic                dataStall
);

  import ahbBusPkg::*;

  logic dataBusy;
  logic dataDone;
  logic instrDone;

  ////////////////////////////////////////////////////////////////////////////
  // State register and next-state logic
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      busState <= idle;
    end else begin
      busState <= nextState;
    end
  end

  always_comb begin
    case (busState)
      idle: begin
        // Atomic first, then loads, stores and finally fetches
        if (dataReq.atomic)     nextState = atomicRead;
        else if (dataReq.read)  nextState = memRead;
        else if (dataReq.write) nextState = memWrite;
        else if (instrReq.read) nextState = instrRead;
        else                    nextState = idle;
      end
      atomicRead: begin
        // Write-back address phase overlaps the read data phase
        nextState = hready ? atomicWrite : atomicRead;
      end
      memRead, memWrite, atomicWrite: begin
        if (!hready)            nextState = busState;
        else if (instrReq.read) nextState = instrRead;
        else                    nextState = idle;
      end
      instrRead: begin
        nextState = hready ? idle : instrRead;
      end
      default: nextState = idle;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stalls and capture strobe
  ////////////////////////////////////////////////////////////////////////////

  assign dataBusy = dataReq.read | dataReq.write | dataReq.atomic;

  // A transfer completes when its final state is left
  assign dataDone  = (busState inside {memRead, memWrite, atomicWrite}) &&
                     (nextState != busState);
  assign instrDone = (busState == instrRead) && (nextState != instrRead);

  assign dataStall  = dataBusy && !dataDone;
  // Also covers the cycles a fetch waits behind data
  assign instrStall = instrReq.read && !instrDone;

  // Old value of an atomic sits on hrdata here
  assign captureOld = (busState == atomicRead) && (nextState == atomicWrite);

  // Write states only follow idle or another data state
  assert property (@(posedge clk) disable iff (reset)
    (busState == instrRead) |=> !(busState inside {memWrite, atomicWrite}))
    else $error("write state entered directly from instrRead");

  // Atomic read completion always starts the write-back
  assert property (@(posedge clk) disable iff (reset)
    (busState == atomicRead && hready) |=> (busState == atomicWrite))
    else $error("atomicRead completed without atomicWrite");

endmodule

/* src/ahbAddrPhase.sv */
////////////////////////////////////////////////////////////////////////////
// AHB address phase, driven combinationally from the next bus state
// Fetches always use the full bus width as hsize
////////////////////////////////////////////////////////////////////////////

module ahbAddrPhase #(
  parameter int Xlen = 64
) (
  input  logic                 clk,
  input  logic                 reset,
  input  ahbBusPkg::busStateT  nextState,
  input  logic                 hready,
  input  ahbBusPkg::instrReqT  instrReq,
  input  ahbBusPkg::dataReqT   dataReq,
  output ahbBusPkg::ahbAddrT   ahbAddr,
  output ahbBusPkg::dataPhaseT dataPhase
);

  import ahbBusPkg::*;

  // log2 of the bus width in bytes
  localparam logic [2:0] FetchSize = 3'($clog2(Xlen / 8));

  logic grantData;

  // Data owns the bus in every data state
  assign grantData = nextState inside {memRead, memWrite, atomicRead, atomicWrite};

  assign ahbAddr.haddr  = grantData ? dataReq.adr : instrReq.adr;
  assign ahbAddr.hsize  = grantData ? {1'b0, dataReq.size} : FetchSize;
  assign ahbAddr.hwrite = nextState inside {memWrite, atomicWrite};
  assign ahbAddr.htrans = (nextState != idle) ? htransNonSeq : htransIdle;

  // Keep what load extraction needs once the address phase is taken
  always_ff @(posedge clk) begin
    if (reset) begin
      dataPhase <= '0;
    end else if (hready && nextState != idle) begin
      dataPhase.lowAdr       <= ahbAddr.haddr[2:0];
      dataPhase.size         <= ahbAddr.hsize[1:0];
      // fetches are never extended
      dataPhase.unsignedLoad <= grantData ? dataReq.unsignedLoad : 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    (ahbAddr.htrans == htransIdle) == (nextState == idle))
    else $error("htrans does not track an idle next state");

endmodule

/* src/ahbDataPath.sv */
////////////////////////////////////////////////////////////////////////////
// Write data, atomic write-back and read return
// Word atomics take their operand from the lane picked by adr[2]
////////////////////////////////////////////////////////////////////////////

module ahbDataPath #(
  parameter int Xlen = 64
) (
  input  logic                 clk,
  input  logic                 reset,
  input  ahbBusPkg::busStateT  busState,
  input  ahbBusPkg::busStateT  nextState,
  input  logic                 captureOld,
  input  ahbBusPkg::dataReqT   dataReq,
  input  ahbBusPkg::dataPhaseT dataPhase,
  input  logic [Xlen-1:0]      writeData,
  input  logic [Xlen-1:0]      hrdata,
  output logic [Xlen-1:0]      hwdata,
  output logic [Xlen-1:0]      dataRdata,
  output logic [Xlen-1:0]      instrRdata
);

  import ahbBusPkg::*;

  logic [Xlen-1:0] readValue;
  logic [Xlen-1:0] amoSrcNew;
  logic [Xlen-1:0] amoResult;
  logic [Xlen-1:0] wdataNext;
  logic [Xlen-1:0] oldValue;

  // Extracted load value, also the old value of an atomic
  subwordRead #(.Xlen(Xlen)) u_subwordRead (
    .hrdata    (hrdata),
    .dataPhase (dataPhase),
    .readValue (readValue)
  );

  // Bring an upper-lane word operand down to bit 0
  assign amoSrcNew = (dataReq.size == 2'd2 && dataReq.adr[2]) ?
                     Xlen'(writeData[Xlen-1 -: 32]) : writeData;

  amoAlu #(.Xlen(Xlen)) u_amoAlu (
    .srcOld (readValue),
    .srcNew (amoSrcNew),
    .amoOp  (dataReq.amoOp),
    .size   (dataReq.size),
    .result (amoResult)
  );

  assign wdataNext = (nextState == atomicWrite) ? amoResult : writeData;

  // Registered at the address-phase edge, held through wait states
  always_ff @(posedge clk) begin
    if (reset) begin
      hwdata <= '0;
    end else if (busState == idle || nextState != busState || captureOld) begin
      hwdata <= wdataNext;
    end
  end

  always_ff @(posedge clk) begin
    if (captureOld) begin
      oldValue <= readValue;
    end
  end

  // Atomics return the value read before the write-back
  assign dataRdata  = (busState == atomicWrite) ? oldValue : readValue;
  assign instrRdata = hrdata;

endmodule

/* src/ahbBusUnit.sv */
////////////////////////////////////////////////////////////////////////////
// AHB-Lite bus interface unit for a fetch port and a data port
// Requests are level held and answered by the stall outputs
// Xlen is 32 or 64, HADDR is always 32 bits
////////////////////////////////////////////////////////////////////////////

module ahbBusUnit #(
  parameter int Xlen = 64
) (
  input  logic                clk,
  input  logic                reset,
  input  ahbBusPkg::instrReqT instrReq,
  input  ahbBusPkg::dataReqT  dataReq,
  input  logic [Xlen-1:0]     writeData,
  input  logic [Xlen-1:0]     hrdata,
  input  logic                hready,
  output ahbBusPkg::ahbAddrT  ahbAddr,
  output logic [Xlen-1:0]     hwdata,
  output logic [Xlen-1:0]     instrRdata,
  output logic [Xlen-1:0]     dataRdata,
  output logic                instrStall,
  output logic                dataStall
);

  import ahbBusPkg::*;

  busStateT  busState;
  busStateT  nextState;
  logic      captureOld;
  dataPhaseT dataPhase;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  ahbBusCtrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .instrReq   (instrReq),
    .dataReq    (dataReq),
    .hready     (hready),
    .busState   (busState),
    .nextState  (nextState),
    .captureOld (captureOld),
    .instrStall (instrStall),
    .dataStall  (dataStall)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Address and data phases
  ////////////////////////////////////////////////////////////////////////////

  ahbAddrPhase #(.Xlen(Xlen)) u_addrPhase (
    .clk       (clk),
    .reset     (reset),
    .nextState (nextState),
    .hready    (hready),
    .instrReq  (instrReq),
    .dataReq   (dataReq),
    .ahbAddr   (ahbAddr),
    .dataPhase (dataPhase)
  );

  ahbDataPath #(.Xlen(Xlen)) u_dataPath (
    .clk        (clk),
    .reset      (reset),
    .busState   (busState),
    .nextState  (nextState),
    .captureOld (captureOld),
    .dataReq    (dataReq),
    .dataPhase  (dataPhase),
    .writeData  (writeData),
    .hrdata     (hrdata),
    .hwdata     (hwdata),
    .dataRdata  (dataRdata),
    .instrRdata (instrRdata)
  );

endmodule

/* tests/tbClock.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench clock with period 4, reset held for 8 rising edges
// Reset drops one time unit after an edge, like all other stimulus
////////////////////////////////////////////////////////////////////////////

module tbClock (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

/* tests/ahbBusTb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the AHB-Lite bus interface unit with Xlen 64
// Slave holds 256 bytes mirrored at every 256-byte boundary
// Inputs change 1 unit after the rising edge and outputs are sampled at negedge
////////////////////////////////////////////////////////////////////////////

module ahbBusTb;

  import ahbBusPkg::*;

  localparam int          Xlen       = 64;
  localparam logic [31:0] MemBase    = 32'h4000_0000;
  localparam int          NumLoads   = 40;
  localparam int          NumPairs   = 30;
  localparam int          NumMixed   = 12;
  // Nine operations at word and double size
  localparam int          NumAtomics = 18;
  // Ten cycles per transfer and two for the reset check
  localparam int          CycleLimit = 10 * (2 + NumLoads + 2 * NumPairs +
                                             2 * NumMixed + 2 * NumAtomics);

  logic            clk;
  logic            reset;
  instrReqT        instrReq;
  dataReqT         dataReq;
  logic [Xlen-1:0] writeData;
  logic [Xlen-1:0] hrdata;
  logic            hready;
  ahbAddrT         ahbAddr;
  logic [Xlen-1:0] hwdata;
  logic [Xlen-1:0] instrRdata;
  logic [Xlen-1:0] dataRdata;
  logic            instrStall;
  logic            dataStall;

  // Slave memory and the reference copy kept from the request rules
  logic [7:0]  mem [256];
  logic [7:0]  refMem [256];
  logic [31:0] rngState;

  // Slave data-phase register
  logic        phaseActive;
  logic [31:0] phaseAddr;
  logic [2:0]  phaseSize;
  logic        phaseWrite;
  int          waitLeft;

  int cycleCount;
  int checkCount;
  int errorCount;
  int testChecks;
  int testErrors;

  tbClock u_clock (
    .clk   (clk),
    .reset (reset)
  );

  ahbBusUnit #(.Xlen(Xlen)) u_dut (
    .clk        (clk),
    .reset      (reset),
    .instrReq   (instrReq),
    .dataReq    (dataReq),
    .writeData  (writeData),
    .hrdata     (hrdata),
    .hready     (hready),
    .ahbAddr    (ahbAddr),
    .hwdata     (hwdata),
    .instrRdata (instrRdata),
    .dataRdata  (dataRdata),
    .instrStall (instrStall),
    .dataStall  (dataStall)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////////////////////////////////////////

  // 32-bit xorshift
  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // Address inside the slave window aligned to the access size
  function automatic logic [31:0] randomAdr(input logic [1:0] size);
    logic [7:0] offset;
    offset = 8'(nextRandom());
    offset = offset & ~8'((1 << size) - 1);
    return MemBase | {24'h0, offset};
  endfunction

  function automatic logic [63:0] slaveDouble(input logic [31:0] adr);
    logic [63:0] value;
    for (int i = 0; i < 8; i++) begin
      value[8 * i +: 8] = mem[{adr[7:3], 3'(i)}];
    end
    return value;
  endfunction

  // Little-endian bytes from the reference sign extended unless unsigned
  function automatic logic [63:0] refLoad(input logic [7:0] adr, input logic [1:0] size,
                                          input logic isUnsigned);
    logic [63:0] value;
    int          bytes;
    value = '0;
    bytes = 1 << size;
    for (int i = 0; i < bytes; i++) begin
      value[8 * i +: 8] = refMem[adr + 8'(i)];
    end
    if (!isUnsigned && bytes < 8 && value[8 * bytes - 1]) begin
      value = value | (~64'd0 << (8 * bytes));
    end
    return value;
  endfunction

  // Store data already sits in its byte lanes
  function automatic void refStore(input logic [7:0] adr, input logic [1:0] size,
                                   input logic [63:0] data);
    logic [7:0] byteAdr;
    for (int i = 0; i < (1 << size); i++) begin
      byteAdr = adr + 8'(i);
      refMem[byteAdr] = data[8 * byteAdr[2:0] +: 8];
    end
  endfunction

  // New memory value of an atomic with word results in both lanes
  function automatic logic [63:0] refAmo(input amoOpT op, input logic [1:0] size,
                                         input logic [63:0] old, input logic [63:0] operand);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    logic        less;
    logic        lessU;
    if (size == 2'd2) begin
      a     = 64'(old[31:0]);
      b     = 64'(operand[31:0]);
      less  = $signed(old[31:0]) < $signed(operand[31:0]);
      lessU = old[31:0] < operand[31:0];
    end else begin
      a     = old;
      b     = operand;
      less  = $signed(old) < $signed(operand);
      lessU = old < operand;
    end
    case (op)
      amoAdd:  r = a + b;
      amoXor:  r = a ^ b;
      amoAnd:  r = a & b;
      amoOr:   r = a | b;
      amoMin:  r = less ? a : b;
      amoMax:  r = less ? b : a;
      amoMinu: r = lessU ? a : b;
      amoMaxu: r = lessU ? b : a;
      default: r = b;
    endcase
    if (size == 2'd2) begin
      r = {r[31:0], r[31:0]};
    end
    return r;
  endfunction

  function automatic int countMismatches();
    int count;
    count = 0;
    for (int i = 0; i < 256; i++) begin
      if (mem[i] !== refMem[i]) begin
        count++;
      end
    end
    return count;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks, slave model and cycle stepping
  ////////////////////////////////////////////////////////////////////////////

  task automatic expectEqual(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    checkCount++;
    testChecks++;
    assert (actual === expected) else begin
      errorCount++;
      testErrors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic startTest();
    testChecks = 0;
    testErrors = 0;
  endtask

  task automatic finishTest(input string name);
    $display("test %s: %0d checks, %0d errors", name, testChecks, testErrors);
  endtask

  // Slave completes or accepts transfers at negedge where the bus is stable
  task automatic sampleCycle();
    logic [7:0] byteAdr;
    @(negedge clk);
    if (phaseActive && hready) begin
      if (phaseWrite) begin
        // Only the bytes named by the registered address and size
        for (int i = 0; i < (1 << phaseSize); i++) begin
          byteAdr = phaseAddr[7:0] + 8'(i);
          mem[byteAdr] = hwdata[8 * byteAdr[2:0] +: 8];
        end
      end
      phaseActive = 1'b0;
    end else if (phaseActive) begin
      waitLeft--;
    end
    if (hready && ahbAddr.htrans == htransNonSeq) begin
      phaseActive = 1'b1;
      phaseAddr   = ahbAddr.haddr;
      phaseSize   = ahbAddr.hsize;
      phaseWrite  = ahbAddr.hwrite;
      waitLeft    = int'(nextRandom() % 4);
    end
  endtask

  // Slave outputs for the new cycle with hready high when no data phase is open
  task automatic nextCycle();
    @(posedge clk);
    #1;
    hready = !phaseActive || waitLeft == 0;
    hrdata = phaseActive ? slaveDouble(phaseAddr) : '0;
  endtask

  // One data request from an idle bus held until its stall drops
  task automatic runData(input dataReqT req, input logic [63:0] wdata,
                         output logic [63:0] rdata);
    int   elapsed;
    int   lowCycles;
    logic done;
    elapsed   = 0;
    lowCycles = 0;
    done      = 1'b0;
    dataReq   = req;
    writeData = wdata;
    while (!done) begin
      sampleCycle();
      if (elapsed == 0) begin
        expectEqual(ahbAddr.htrans, htransNonSeq, "htrans at first address phase");
        expectEqual(ahbAddr.haddr, req.adr, "haddr");
        expectEqual(ahbAddr.hsize, {1'b0, req.size}, "hsize");
        expectEqual(ahbAddr.hwrite, req.write, "hwrite");
      end
      if (!hready) begin
        lowCycles++;
      end
      if (!dataStall) begin
        done = 1'b1;
      end else begin
        nextCycle();
        elapsed++;
      end
    end
    rdata = dataRdata;
    if (req.write) begin
      expectEqual(hwdata, wdata, "hwdata in data phase");
    end
    // Atomic pays one extra cycle for the write-back
    expectEqual(elapsed, lowCycles + (req.atomic ? 2 : 1), "cycles to stall release");
    nextCycle();
    dataReq   = '0;
    writeData = '0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkIdle();
    startTest();
    repeat (3) begin
      sampleCycle();
      expectEqual(ahbAddr.htrans, htransIdle, "htrans after reset");
      expectEqual(ahbAddr.hwrite, 0, "hwrite after reset");
      expectEqual(dataStall, 0, "dataStall after reset");
      expectEqual(instrStall, 0, "instrStall after reset");
      nextCycle();
    end
    finishTest("idle after reset");
  endtask

  task automatic testLoads();
    dataReqT     req;
    logic [63:0] rdata;
    logic [63:0] expected;
    startTest();
    for (int n = 0; n < NumLoads; n++) begin
      req              = '0;
      req.read         = 1'b1;
      req.size         = 2'(nextRandom());
      req.unsignedLoad = 1'(nextRandom());
      req.adr          = randomAdr(req.size);
      expected         = refLoad(req.adr[7:0], req.size, req.unsignedLoad);
      runData(req, '0, rdata);
      expectEqual(rdata, expected, "load data");
    end
    finishTest("random loads");
  endtask

  task automatic testStoreLoad();
    dataReqT     req;
    logic [63:0] wdata;
    logic [63:0] rdata;
    logic [63:0] expected;
    startTest();
    for (int n = 0; n < NumPairs; n++) begin
      req       = '0;
      req.write = 1'b1;
      req.size  = 2'(nextRandom());
      req.adr   = randomAdr(req.size);
      wdata     = {nextRandom(), nextRandom()};
      runData(req, wdata, rdata);
      refStore(req.adr[7:0], req.size, wdata);
      expectEqual(countMismatches(), 0, "bytes differing from reference after store");
      // Read back the same location
      req.write        = 1'b0;
      req.read         = 1'b1;
      req.unsignedLoad = 1'(nextRandom());
      expected         = refLoad(req.adr[7:0], req.size, req.unsignedLoad);
      runData(req, '0, rdata);
      expectEqual(rdata, expected, "load after store");
    end
    finishTest("stores then loads");
  endtask

  // Fetch and load raised together so data wins and the fetch follows
  task automatic testMixed();
    dataReqT     req;
    logic [31:0] fetchAdr;
    logic [63:0] expected;
    int          elapsed;
    int          fetchStart;
    int          fetchLow;
    logic        dataDone;
    logic        instrDone;
    startTest();
    for (int n = 0; n < NumMixed; n++) begin
      req              = '0;
      req.read         = 1'b1;
      req.size         = 2'(nextRandom());
      req.unsignedLoad = 1'(nextRandom());
      req.adr          = randomAdr(req.size);
      fetchAdr         = randomAdr(2'd3);
      expected         = refLoad(req.adr[7:0], req.size, req.unsignedLoad);
      dataReq          = req;
      instrReq.read    = 1'b1;
      instrReq.adr     = fetchAdr;
      elapsed          = 0;
      fetchStart       = 0;
      fetchLow         = 0;
      dataDone         = 1'b0;
      instrDone        = 1'b0;
      while (!instrDone) begin
        sampleCycle();
        if (elapsed == 0) begin
          expectEqual(ahbAddr.haddr, req.adr, "first haddr with both requests");
        end
        if (!dataDone && !dataStall) begin
          expectEqual(dataRdata, expected, "load data ahead of fetch");
          // Fetch address phase overlaps the last data cycle
          expectEqual(ahbAddr.htrans, htransNonSeq, "htrans at data completion");
          expectEqual(ahbAddr.haddr, fetchAdr, "fetch haddr");
          expectEqual(ahbAddr.hsize, 3'd3, "fetch hsize");
          expectEqual(ahbAddr.hwrite, 1'b0, "fetch hwrite");
          fetchStart = elapsed;
          dataDone   = 1'b1;
          nextCycle();
          dataReq = '0;
        end else begin
          if (dataDone && !hready) begin
            fetchLow++;
          end
          if (dataDone && !instrStall) begin
            expectEqual(instrRdata, refLoad(fetchAdr[7:0], 2'd3, 1'b1), "fetch data");
            expectEqual(elapsed - fetchStart, fetchLow + 1, "cycles to fetch stall release");
            instrDone = 1'b1;
          end
          nextCycle();
        end
        elapsed++;
      end
      instrReq = '0;
    end
    finishTest("fetch behind data");
  endtask

  task automatic testAtomics();
    dataReqT     req;
    logic [63:0] operand;
    logic [63:0] oldValue;
    logic [63:0] rdata;
    startTest();
    for (int s = 2; s <= 3; s++) begin
      for (int op = 0; op < 9; op++) begin
        req        = '0;
        req.atomic = 1'b1;
        req.amoOp  = amoOpT'(op);
        req.size   = 2'(s);
        req.adr    = randomAdr(req.size);
        operand    = {nextRandom(), nextRandom()};
        // Word operand placed in both lanes
        if (s == 2) begin
          operand = {operand[31:0], operand[31:0]};
        end
        oldValue = refLoad(req.adr[7:0], req.size, 1'b0);
        runData(req, operand, rdata);
        expectEqual(rdata, oldValue, "atomic old value");
        refStore(req.adr[7:0], req.size, refAmo(req.amoOp, req.size, oldValue, operand));
        expectEqual(countMismatches(), 0, "bytes differing from reference after atomic");
      end
    end
    finishTest("atomics");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rngState    = 32'd45710;
    instrReq    = '0;
    dataReq     = '0;
    writeData   = '0;
    hrdata      = '0;
    hready      = 1'b1;
    phaseActive = 1'b0;
    phaseAddr   = '0;
    phaseSize   = '0;
    phaseWrite  = 1'b0;
    waitLeft    = 0;
    checkCount  = 0;
    errorCount  = 0;
    // Every byte differs with its full address
    for (int i = 0; i < 256; i++) begin
      mem[i]    = 8'((i * 151) ^ (i >> 3) ^ 8'h5a);
      refMem[i] = mem[i];
    end
    @(negedge reset);
    checkIdle();
    testLoads();
    testStoreLoad();
    testMixed();
    testAtomics();
    $display("total: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog on rising edges
  initial begin
    cycleCount = 0;
    while (cycleCount <= CycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: tests still running after %0d cycles", cycleCount);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* ahbBus.f */
src/ahbBusPkg.sv
src/subwordRead.sv
src/amoAlu.sv
src/ahbBusCtrl.sv
src/ahbAddrPhase.sv
src/ahbDataPath.sv
src/ahbBusUnit.sv
tests/tbClock.sv
tests/ahbBusTb.sv

/* Bender.yml */
package:
  name: ahbBus

sources:
  # Package first, leaf modules before the blocks that use them
  - src/ahbBusPkg.sv
  - src/subwordRead.sv
  - src/amoAlu.sv
  - src/ahbBusCtrl.sv
  - src/ahbAddrPhase.sv
  - src/ahbDataPath.sv
  - src/ahbBusUnit.sv

  # Testbench, top module ahbBusTb
  - target: test
    files:
      - tests/tbClock.sv
      - tests/ahbBusTb.sv
